//--- common/ac97_cfg.svh
`ifndef AC97_CFG_SVH
`define AC97_CFG_SVH

// ----------------------------------------
// sample strobe divider
// ----------------------------------------
// 125 MHz / 48 kHz = 2604.1666, so five short runs of 2604 cycles
// and one long run of 2605 cycles give the exact average
`define AC97_TICK_CTR_MAX 2604   // last count value of a run
`define AC97_TICK_FRC_MAX 5      // short runs before the long run

// ----------------------------------------
// sample fifos
// ----------------------------------------
`define AC97_FIFO_DEPTH 16       // stereo pairs per fifo
`define AC97_CNT_W 5             // count 0..16
`define AC97_SAMPLE_W 16         // one channel

// ----------------------------------------
// system bus
// ----------------------------------------
`define AC97_BUS_AW 20           // decoded offset bits
`define AC97_BUS_DW 32           // data width

// register offsets
`define AC97_ADDR_PLAY 20'h00000       // play fifo, write only
`define AC97_ADDR_REC 20'h00004        // record fifo, read only
`define AC97_ADDR_STAT 20'h00008       // status word, read only
`define AC97_ADDR_FIFO_RST 20'h0000C   // fifo flush, write only

`endif

//--- common/ac97_pkg.sv
`include "ac97_cfg.svh"

package ac97_pkg;

  // ----------------------------------------
  // payload types
  // ----------------------------------------

  // right in the upper half, left in the lower half
  typedef struct packed {
    logic [`AC97_SAMPLE_W-1:0] right;  // bits 31:16
    logic [`AC97_SAMPLE_W-1:0] left;   // bits 15:0
  } sample_pair_t;

  typedef struct packed {
    logic [`AC97_CNT_W-1:0] count;  // entries held
    logic                   empty;  // count == 0
    logic                   full;   // count == depth
    logic                   half;   // at least half the depth
    logic                   lost;   // sticky over/underrun
  } fifo_status_t;

  // ----------------------------------------
  // bus types
  // ----------------------------------------
  typedef struct packed {
    logic [`AC97_BUS_AW-1:0] addr;   // byte offset
    logic [`AC97_BUS_DW-1:0] wdata;  // write data
    logic                    wen;    // one-cycle write strobe
    logic                    ren;    // one-cycle read strobe
  } bus_req_t;

  typedef struct packed {
    logic [`AC97_BUS_DW-1:0] rdata;  // valid with ack
    logic                    ack;    // one cycle after the request
  } bus_rsp_t;

  typedef enum logic [`AC97_BUS_AW-1:0] {
    reg_play     = `AC97_ADDR_PLAY,
    reg_rec      = `AC97_ADDR_REC,
    reg_stat     = `AC97_ADDR_STAT,
    reg_fifo_rst = `AC97_ADDR_FIFO_RST
  } reg_addr_e;

  // fill-level condition that raises a fifo interrupt
  typedef enum logic [2:0] {
    irq_none       = 3'd0,  // held low
    irq_empty      = 3'd1,  // count == 0
    irq_half_empty = 3'd2,  // count <= 7
    irq_half_full  = 3'd3,  // count >= 8
    irq_full       = 3'd4   // count == 16
  } irq_level_e;

endpackage

//--- dv/ac97_stim.txt
# op test arg1 arg2 in hex; wr addr data, rd addr expect, li pair 0, ws strobes 0
# lo pair 0, iq play_irq rec_irq, fill strobes 0, drain pairs 0
ws strobe 0c 0
rd bus 10 0
wr bus 20 deadbeef
rd bus 0 0
rd bus 8 40
wr flush c 3
rd flush 8 8
iq flush 1 0
wr play 0 1111
wr play 0 2222
wr play 0 3333
wr play 0 4444
rd play 8 8
iq play 1 0
ws play 1 0
lo play 22221111 0
ws play 1 0
lo play 44443333 0
ws play 1 0
lo play 44443333 0
rd play 8 40
wr record c 2
li record 0bb00aa0 0
ws record 1 0
li record 0dd00cc0 0
ws record 1 0
rd record 4 0aa0
rd record 4 0bb0
rd record 4 0cc0
rd record 4 0dd0
rd record 8 48
fill fill 12 0
rd fill 8 c4
iq fill 1 1
drain fill 10 0
rd fill 8 c8

//--- dv/ac97_tb_tasks.svh
`ifndef AC97_TB_TASKS_SVH
`define AC97_TB_TASKS_SVH

// ----------------------------------------
// error lines
// ----------------------------------------
task automatic report_value(input name_t name, input string exp_s, input string act_s);
  $display("Mismatch in %0s: expected %0s, actual %0s", name, exp_s, act_s);
  test_errs++;
endtask

task automatic report_failure(input name_t name, input string msg);
  $display("Error in %0s: %0s", name, msg);
  test_errs++;
endtask

// ----------------------------------------
// typed compares
// ----------------------------------------
task automatic check_pair(input name_t name, input sample_pair_t exp_v,
                          input sample_pair_t act_v);
  if (act_v !== exp_v)
    report_value(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
endtask

task automatic check_word(input name_t name, input logic [`AC97_BUS_DW-1:0] exp_v,
                          input logic [`AC97_BUS_DW-1:0] act_v);
  if (act_v !== exp_v)
    report_value(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
endtask

task automatic check_bit(input name_t name, input logic exp_v, input logic act_v);
  if (act_v !== exp_v)
    report_value(name, $sformatf("%b", exp_v), $sformatf("%b", act_v));
endtask

task automatic check_tick_gap(input name_t name, input int exp_v, input int act_v);
  if (act_v != exp_v)
    report_value(name, $sformatf("gap %0d", exp_v), $sformatf("gap %0d", act_v));
endtask

// ----------------------------------------
// bus access and strobe waits
// ----------------------------------------
task automatic bus_access(input name_t name, input logic wr,
                          input logic [`AC97_BUS_AW-1:0] addr,
                          input logic [`AC97_BUS_DW-1:0] wdata,
                          output logic [`AC97_BUS_DW-1:0] rdata);
  @(posedge clk_adc_125mhz);
  bus_req.addr  <= addr;
  bus_req.wdata <= wdata;
  bus_req.wen   <= wr;
  bus_req.ren   <= !wr;
  @(posedge clk_adc_125mhz);
  bus_req <= '0;                 // one-cycle strobe
  @(posedge clk_adc_125mhz);     // ack cycle
  rdata = bus_rsp.rdata;
  if (bus_rsp.ack !== 1'b1)
    report_failure(name, "no ack one cycle after the request");
  @(posedge clk_adc_125mhz);
  if (bus_rsp.ack !== 1'b0)
    report_failure(name, "ack lasted more than one cycle");
endtask

task automatic wait_strobes(input name_t name, input int n);
  int seen;
  seen = 0;
  while (seen < n) begin
    @(posedge clk_adc_125mhz);
    if (clks[1])
      seen++;
  end
  repeat (2) @(posedge clk_adc_125mhz);  // line out and irq settle
  while (gap_q.size() > 0) begin
    tick_idx++;
    check_tick_gap(name, (tick_idx % GROUP == 1) ? GAP_LONG : GAP_SHORT, gap_q.pop_front());
    check_bit(name, (tick_idx % GROUP == 0), tick8_q.pop_front());  // 8k on every sixth
  end
  if (stray_8k != 0)
    report_failure(name, "8 kHz strobe seen without a 48 kHz strobe");
  stray_8k = 0;
endtask

// one stim line
task automatic run_op(input logic [63:0] op, input name_t name,
                      input logic [31:0] arg1, input logic [31:0] arg2);
  logic [`AC97_BUS_DW-1:0] rdata;
  logic [`AC97_BUS_DW-1:0] left_w;
  sample_pair_t            pair;
  case (op)
    "wr": bus_access(name, 1'b1, arg1[`AC97_BUS_AW-1:0], arg2, rdata);
    "rd": begin
      bus_access(name, 1'b0, arg1[`AC97_BUS_AW-1:0], '0, rdata);
      check_word(name, arg2, rdata);
    end
    "li": begin
      @(posedge clk_adc_125mhz);
      line_in <= arg1;
    end
    "ws": wait_strobes(name, arg1);
    "lo": begin
      @(posedge clk_adc_125mhz);
      check_pair(name, arg1, line_out);
    end
    "iq": begin
      @(posedge clk_adc_125mhz);
      check_bit(name, arg1[0], irq_play);
      check_bit(name, arg2[0], irq_rec);
    end
    "fill": repeat (arg1) begin
      @(posedge clk_adc_125mhz);
      pair = $random(seed);
      line_in <= pair;
      fill_q.push_back(pair);
      wait_strobes(name, 1);
    end
    "drain": begin
      repeat (arg1) begin
        bus_access(name, 1'b0, `AC97_ADDR_REC, '0, left_w);  // left half first
        bus_access(name, 1'b0, `AC97_ADDR_REC, '0, rdata);
        pair.left  = left_w[`AC97_SAMPLE_W-1:0];
        pair.right = rdata[`AC97_SAMPLE_W-1:0];
        check_pair(name, fill_q.pop_front(), pair);
      end
      fill_q.delete();  // values captured while full never entered
    end
    default: report_failure(name, "unknown operation in the stimulus file");
  endcase
endtask

`endif

//--- dv/tb_ac97_ctrl.sv
`timescale 1ns/10ps
`include "ac97_cfg.svh"

module tb_ac97_ctrl import ac97_pkg::*; ();

  typedef logic [8*24-1:0] name_t;  // test name as read from the stim file

  localparam int GAP_SHORT = `AC97_TICK_CTR_MAX;      // 2604 cycles
  localparam int GAP_LONG  = `AC97_TICK_CTR_MAX + 1;  // 2605 cycles
  localparam int GROUP     = `AC97_TICK_FRC_MAX + 1;  // 48k strobes per 8k strobe

  logic         clk_adc_125mhz = 1'b0;
  logic         adc_rstn;
  logic [1:0]   clks;       // {48k, 8k}
  sample_pair_t line_out;
  sample_pair_t line_in;
  logic         irq_play;
  logic         irq_rec;
  bus_req_t     bus_req;
  bus_rsp_t     bus_rsp;

  int           test_errs = 0;     // errors in the running test
  int           total_errs = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  int           wd_cycles = 0;     // watchdog limit in cycles
  int           gap_ctr = 0;       // cycles since the last 48k strobe
  int           tick_idx = 0;      // 48k strobes checked so far
  int           stray_8k = 0;
  integer       seed;
  name_t        cur_name;
  int           gap_q[$];          // one gap per 48k strobe
  logic         tick8_q[$];        // 8k seen with that strobe
  sample_pair_t fill_q[$];         // line-in values of the fill op
  logic [63:0]  op_q[$];
  name_t        name_q[$];
  logic [31:0]  arg1_q[$];
  logic [31:0]  arg2_q[$];

  ac97_ctrl_top u_ac97_ctrl_top (
    .clk_adc_125mhz  (clk_adc_125mhz),
    .adc_rstn_i      (adc_rstn),
    .ac97_clks_o     (clks),
    .ac97_line_out_o (line_out),
    .ac97_line_in_i  (line_in),
    .ac97_irq_play_o (irq_play),
    .ac97_irq_rec_o  (irq_rec),
    .bus_req_i       (bus_req),
    .bus_rsp_o       (bus_rsp)
  );

  always #4 clk_adc_125mhz = ~clk_adc_125mhz;  // 8 ns period

  `include "ac97_tb_tasks.svh"

  // ----------------------------------------
  // strobe monitor
  // ----------------------------------------
  always @(posedge clk_adc_125mhz) begin
    if (!adc_rstn) begin
      gap_ctr = -1;  // release edge counts as zero
    end else begin
      gap_ctr++;
      if (clks[1]) begin
        gap_q.push_back(gap_ctr);
        tick8_q.push_back(clks[0]);
        gap_ctr = 0;
      end else if (clks[0]) begin
        stray_8k++;  // 8k without 48k
      end
    end
  end

  // stim file into the op queues, watchdog budget from the waits
  function automatic bit load_stim();
    int               fd;
    int               code;
    int               budget;
    logic [8*160-1:0] line;
    logic [63:0]      op;
    name_t            name;
    logic [31:0]      arg1;
    logic [31:0]      arg2;
    budget = 0;
    fd = $fopen("dv/ac97_stim.txt", "r");
    if (fd == 0)
      return 1'b0;
    while (!$feof(fd)) begin
      line = '0;
      code = $fgets(line, fd);
      code = $sscanf(line, "%s %s %h %h", op, name, arg1, arg2);
      if (code == 4 && op != "#") begin
        op_q.push_back(op);
        name_q.push_back(name);
        arg1_q.push_back(arg1);
        arg2_q.push_back(arg2);
        if (op == "ws" || op == "fill")
          budget += arg1 * GAP_LONG;  // worst case per strobe
        else if (op == "drain")
          budget += arg1 * 40;        // two reads per pair
        else
          budget += 20;
      end
    end
    $fclose(fd);
    wd_cycles = 2 * budget;
    return 1'b1;
  endfunction

  function automatic void close_test();
    if (cur_name != '0) begin
      tests_run++;
      if (test_errs != 0) begin
        tests_failed++;
        $display("test %0s: failed with %0d errors", cur_name, test_errs);
      end else begin
        $display("test %0s: passed", cur_name);
      end
      total_errs += test_errs;
      test_errs = 0;
    end
  endfunction

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    adc_rstn = 1'b0;
    line_in  = '0;
    bus_req  = '0;
    seed     = 32'h7351_1a6d;
    cur_name = '0;
    if (!load_stim()) begin
      $display("cannot open the stimulus file dv/ac97_stim.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      repeat (8) @(posedge clk_adc_125mhz);
      adc_rstn <= 1'b1;
      for (int i = 0; i < op_q.size(); i++) begin
        if (name_q[i] != cur_name) begin
          close_test();  // a new name starts the next test
          cur_name = name_q[i];
        end
        run_op(op_q[i], name_q[i], arg1_q[i], arg2_q[i]);
      end
      close_test();
      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
      if (total_errs == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
      $finish;
    end
  end

  // watchdog, armed once the budget is known
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_adc_125mhz);
    $display("timeout: stimulus still running after %0d cycles", wd_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- fifo/sample_fifo.sv
`timescale 1ns/10ps
`include "ac97_cfg.svh"

module sample_fifo import ac97_pkg::*; #(
  parameter irq_level_e IRQ_LEVEL = irq_none  // interrupt condition
) (
  input  logic         clk_adc_125mhz,  // adc clock
  input  logic         adc_rstn_i,      // sync reset, active low
  input  logic         flush_i,         // empty the fifo, clear lost
  input  logic         push_i,          // write one pair
  input  sample_pair_t push_data_i,     // pair to write
  input  logic         pop_i,           // drop the head pair
  output sample_pair_t head_o,          // oldest pair, no pop needed
  output fifo_status_t status_o,        // count and flags
  output logic         irq_o            // registered fill-level interrupt
);

  localparam int PTR_W = $clog2(`AC97_FIFO_DEPTH);
  localparam logic [`AC97_CNT_W-1:0] CNT_FULL = `AC97_CNT_W'(`AC97_FIFO_DEPTH);
  localparam logic [`AC97_CNT_W-1:0] CNT_HALF = `AC97_CNT_W'(`AC97_FIFO_DEPTH / 2);

  sample_pair_t           mem [`AC97_FIFO_DEPTH];  // circular buffer
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [`AC97_CNT_W-1:0] count;
  logic                   lost_q;   // sticky over/underrun
  logic                   is_empty;
  logic                   is_full;
  logic                   do_push;  // accepted push
  logic                   do_pop;   // accepted pop

  assign is_empty = (count == '0);
  assign is_full  = (count == CNT_FULL);
  assign do_push  = push_i && !is_full;   // push into full is dropped
  assign do_pop   = pop_i && !is_empty;   // pop from empty does nothing

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push && !flush_i)
      mem[wr_ptr] <= push_data_i;
  end

  assign head_o = mem[rd_ptr];  // read-ahead head

  // ----------------------------------------
  // pointers, count and lost
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      lost_q <= 1'b0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
      if ((push_i && is_full) || (pop_i && is_empty))
        lost_q <= 1'b1;
    end
  end

  assign status_o = '{count: count, empty: is_empty, full: is_full,
                      half: (count >= CNT_HALF), lost: lost_q};

  // ----------------------------------------
  // interrupt level, follows the count one cycle later
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      irq_o <= 1'b0;
    end else begin
      case (IRQ_LEVEL)
        irq_empty:      irq_o <= is_empty;
        irq_half_empty: irq_o <= (count < CNT_HALF);   // 7 or fewer
        irq_half_full:  irq_o <= (count >= CNT_HALF);  // 8 or more
        irq_full:       irq_o <= is_full;
        default:        irq_o <= 1'b0;                 // irq_none
      endcase
    end
  end

endmodule

//--- tb.f
+incdir+common
+incdir+dv
common/ac97_pkg.sv
verilog/sample_tick_gen.sv
fifo/sample_fifo.sv
verilog/ac97_bus_regs.sv
verilog/ac97_ctrl_top.sv
dv/tb_ac97_ctrl.sv

//--- verilog/ac97_bus_regs.sv
`timescale 1ns/10ps
`include "ac97_cfg.svh"

module ac97_bus_regs import ac97_pkg::*; (
  input  logic         clk_adc_125mhz,  // adc clock
  input  logic         adc_rstn_i,      // sync reset, active low
  input  bus_req_t     bus_req_i,       // cpu request
  output bus_rsp_t     bus_rsp_o,       // rdata and ack
  output logic         play_push_o,     // pair assembled
  output sample_pair_t play_data_o,     // assembled play pair
  output logic         play_flush_o,    // flush play fifo
  input  sample_pair_t rec_head_i,      // record fifo head
  output logic         rec_pop_o,       // pair fully read
  output logic         rec_flush_o,     // flush record fifo
  input  fifo_status_t play_stat_i,     // play fifo state
  input  fifo_status_t rec_stat_i       // record fifo state
);

  localparam int PAD_W = `AC97_BUS_DW - `AC97_SAMPLE_W;

  logic                    ack_q;
  logic [`AC97_BUS_DW-1:0] rdata_q;
  logic [`AC97_BUS_DW-1:0] stat_word;     // packed status register
  sample_pair_t            play_pair_q;   // left/right being assembled
  logic                    play_is_right; // next play write is the right half
  logic                    rec_is_right;  // next record read is the right half
  logic                    play_push_q;
  logic                    play_flush_q;
  logic                    rec_flush_q;
  logic                    rec_pop_q;

  // status word, bit 0 upward
  assign stat_word = {{(`AC97_BUS_DW-8){1'b0}},
                      rec_stat_i.lost,     // bit 7
                      play_stat_i.lost,    // bit 6
                      2'b00,               // bits 5:4 reserved
                      rec_stat_i.empty,    // bit 3
                      rec_stat_i.full,     // bit 2
                      play_stat_i.half,    // bit 1
                      play_stat_i.full};   // bit 0

  // ----------------------------------------
  // control strobes and half selection
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ack_q         <= 1'b0;
      play_is_right <= 1'b0;
      rec_is_right  <= 1'b0;
      play_push_q   <= 1'b0;
      play_flush_q  <= 1'b0;
      rec_flush_q   <= 1'b0;
      rec_pop_q     <= 1'b0;
    end else begin
      ack_q        <= bus_req_i.wen || bus_req_i.ren;  // any address
      play_push_q  <= 1'b0;  // pulse defaults
      play_flush_q <= 1'b0;
      rec_flush_q  <= 1'b0;
      rec_pop_q    <= 1'b0;
      if (bus_req_i.wen) begin
        case (bus_req_i.addr)
          reg_play: begin
            play_is_right <= !play_is_right;
            play_push_q   <= play_is_right;  // second write completes the pair
          end
          reg_fifo_rst: begin
            play_flush_q <= bus_req_i.wdata[0];
            rec_flush_q  <= bus_req_i.wdata[1];
            if (bus_req_i.wdata[0])
              play_is_right <= 1'b0;  // restart pairing at left
            if (bus_req_i.wdata[1])
              rec_is_right <= 1'b0;   // restart reads at left
          end
          default: ;  // ignored, still acked
        endcase
      end else if (bus_req_i.ren && (bus_req_i.addr == reg_rec)) begin
        rec_is_right <= !rec_is_right;
        rec_pop_q    <= rec_is_right;  // right half read drops the pair
      end
    end
  end

  // ----------------------------------------
  // play pair and read data
  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (bus_req_i.wen && (bus_req_i.addr == reg_play)) begin
      if (play_is_right)
        play_pair_q.right <= bus_req_i.wdata[`AC97_SAMPLE_W-1:0];
      else
        play_pair_q.left <= bus_req_i.wdata[`AC97_SAMPLE_W-1:0];
    end
    rdata_q <= '0;  // zero outside read cycles
    if (bus_req_i.ren) begin
      case (bus_req_i.addr)
        reg_rec: begin
          if (rec_is_right)
            rdata_q <= {{PAD_W{1'b0}}, rec_head_i.right};
          else
            rdata_q <= {{PAD_W{1'b0}}, rec_head_i.left};
        end
        reg_stat: rdata_q <= stat_word;
        default:  rdata_q <= '0;  // write-only or unknown
      endcase
    end
  end

  assign bus_rsp_o    = '{rdata: rdata_q, ack: ack_q};
  assign play_push_o  = play_push_q;
  assign play_data_o  = play_pair_q;
  assign play_flush_o = play_flush_q;
  assign rec_flush_o  = rec_flush_q;
  assign rec_pop_o    = rec_pop_q;

endmodule

//--- verilog/ac97_ctrl_top.sv
`timescale 1ns/10ps

module ac97_ctrl_top import ac97_pkg::*; (
  input  logic         clk_adc_125mhz,   // adc clock
  input  logic         adc_rstn_i,       // sync reset, active low
  output logic [1:0]   ac97_clks_o,      // {48k, 8k} strobes
  output sample_pair_t ac97_line_out_o,  // play samples
  input  sample_pair_t ac97_line_in_i,   // record samples
  output logic         ac97_irq_play_o,  // play fifo interrupt
  output logic         ac97_irq_rec_o,   // record fifo interrupt
  input  bus_req_t     bus_req_i,        // cpu request
  output bus_rsp_t     bus_rsp_o         // cpu response
);

  logic         tick_48k;
  logic         tick_8k;
  logic         play_push;
  sample_pair_t play_data;
  logic         play_flush;
  sample_pair_t play_head;
  fifo_status_t play_stat;
  logic         rec_pop;
  logic         rec_flush;
  sample_pair_t rec_head;
  fifo_status_t rec_stat;

  sample_tick_gen u_tick_gen (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .tick_48k_o     (tick_48k),
    .tick_8k_o      (tick_8k)
  );

  assign ac97_clks_o = {tick_48k, tick_8k};

  // ----------------------------------------
  // play path, cpu to line out
  // ----------------------------------------
  sample_fifo #(.IRQ_LEVEL(irq_half_empty)) u_play_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .flush_i        (play_flush),
    .push_i         (play_push),
    .push_data_i    (play_data),
    .pop_i          (tick_48k),  // one pair per strobe
    .head_o         (play_head),
    .status_o       (play_stat),
    .irq_o          (ac97_irq_play_o)
  );

  // line out holds the popped pair until the next strobe
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i)
      ac97_line_out_o <= '0;
    else if (tick_48k && !play_stat.empty)
      ac97_line_out_o <= play_head;  // empty keeps the last pair
  end

  // ----------------------------------------
  // record path, line in to cpu
  // ----------------------------------------
  sample_fifo #(.IRQ_LEVEL(irq_half_full)) u_rec_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .flush_i        (rec_flush),
    .push_i         (tick_48k),  // capture on each strobe
    .push_data_i    (ac97_line_in_i),
    .pop_i          (rec_pop),
    .head_o         (rec_head),
    .status_o       (rec_stat),
    .irq_o          (ac97_irq_rec_o)
  );

  ac97_bus_regs u_bus_regs (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .bus_req_i      (bus_req_i),
    .bus_rsp_o      (bus_rsp_o),
    .play_push_o    (play_push),
    .play_data_o    (play_data),
    .play_flush_o   (play_flush),
    .rec_head_i     (rec_head),
    .rec_pop_o      (rec_pop),
    .rec_flush_o    (rec_flush),
    .play_stat_i    (play_stat),
    .rec_stat_i     (rec_stat)
  );

endmodule

//--- verilog/sample_tick_gen.sv
`timescale 1ns/10ps
`include "ac97_cfg.svh"

module sample_tick_gen (
  input  logic clk_adc_125mhz,  // adc clock
  input  logic adc_rstn_i,      // sync reset, active low
  output logic tick_48k_o,      // one-cycle 48 kHz strobe
  output logic tick_8k_o        // one-cycle 8 kHz strobe
);

  localparam logic [11:0] CTR_MAX = 12'(`AC97_TICK_CTR_MAX);
  localparam logic [2:0]  FRC_MAX = 3'(`AC97_TICK_FRC_MAX);

  logic [11:0] run_ctr;  // position inside the current run
  logic [2:0]  frc_ctr;  // short runs done in this group

  // ----------------------------------------
  // fractional divider
  // ----------------------------------------
  // a run restarting at 1 is 2604 cycles long, one restarting at 0 is 2605.
  // five short runs, then one long run, six strobes per 15625 cycles
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      run_ctr    <= '0;     // first run is a long one
      frc_ctr    <= '0;
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
    end else if (run_ctr == CTR_MAX) begin
      tick_48k_o <= 1'b1;   // end of every run
      if (frc_ctr == FRC_MAX) begin
        frc_ctr   <= '0;
        run_ctr   <= '0;    // long run follows
        tick_8k_o <= 1'b1;  // once per group of six
      end else begin
        frc_ctr   <= frc_ctr + 3'd1;
        run_ctr   <= 12'd1; // short run follows
        tick_8k_o <= 1'b0;
      end
    end else begin
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
      run_ctr    <= run_ctr + 12'd1;
    end
  end

endmodule
